// File: src/adc_capture_pkg.sv
// shared widths and strobe timing for a 16-bit parallel ADC whose RD and CONVST minimums fit in two sys_clk cycles
`default_nettype none

package adc_capture_pkg;

    // ********************
    // data path widths
    // ********************

    // one conversion result as it appears on the DB pins
    localparam int ADC_DATA_W = 16;

    // channel index covers 0 to 16, so 17 channels at most
    localparam int ADC_CH_W = 5;

    // oversampling and status configuration mode
    localparam int ADC_MODE_W = 2;

    typedef logic [ADC_DATA_W-1:0] adc_data_t;
    typedef logic [ADC_CH_W-1:0]   adc_ch_t;
    typedef logic [ADC_MODE_W-1:0] adc_mode_t;

    // ********************
    // strobe timing
    // ********************

    // all counts are in sys_clk cycles
    localparam int ADC_RD_LOW_CYCLES  = 2;
    localparam int ADC_RD_HIGH_CYCLES = 2;
    localparam int ADC_CNVST_CYCLES   = 2;

    // wide enough for every strobe counter above
    localparam int ADC_STROBE_CNT_W = 3;

    // ********************
    // sample buffering
    // ********************

    // the depth has to stay a power of two so the pointers wrap on their own
    localparam int SAMPLE_FIFO_DEPTH = 4;
    localparam int SAMPLE_FIFO_PTR_W = $clog2(SAMPLE_FIFO_DEPTH);

    // conversion controller states
    typedef enum logic [2:0] {
        CONV_IDLE,
        CONV_CONVERT,
        CONV_WAIT_BUSY_HI,
        CONV_WAIT_BUSY_LO,
        CONV_READ
    } conv_state_e;

    // read engine states
    typedef enum logic [1:0] {
        RD_IDLE,
        RD_STROBE_LOW,
        RD_HOLD,
        RD_GAP
    } rd_state_e;

endpackage

`default_nettype wire

// File: src/adc_conv_ctrl.sv
// adc_busy_i is taken as synchronous to sys_clk and a conversion that never raises BUSY stalls here
`timescale 1ns/100ps
`default_nettype none

module adc_conv_ctrl import adc_capture_pkg::*; (
    input  wire             sys_clk,
    input  wire             rst_i,
    // conversion request port
    input  wire             conv_valid_i,
    output logic            conv_ready_o,
    input  wire adc_mode_t  config_mode_i,
    // ADC conversion pins
    input  wire             adc_busy_i,
    output logic            adc_cnvst_n_o,
    // hand-off to the read engine
    output logic            rd_start_o,
    output adc_ch_t         rd_num_ch_o,
    input  wire             rd_done_i
);

    conv_state_e                 state;
    logic [ADC_STROBE_CNT_W-1:0] cnvst_cnt;
    adc_mode_t                   mode_q;
    adc_ch_t                     num_ch;
    logic                        accept;

    // a new request is only taken once the previous frame has fully left the reader
    assign conv_ready_o = (state == CONV_IDLE);
    assign accept       = conv_valid_i && conv_ready_o;

    // ********************
    // mode to channel count
    // ********************

    // modes 1 and 3 append the status word after the data channels
    always_comb begin
        case (mode_q)
            2'd0:    num_ch = adc_ch_t'(8);
            2'd1:    num_ch = adc_ch_t'(9);
            2'd2:    num_ch = adc_ch_t'(16);
            default: num_ch = adc_ch_t'(17);
        endcase
    end

    // the mode is held for the whole frame, so the count stays valid with rd_start_o
    always_ff @(posedge sys_clk) begin
        if (accept) begin
            mode_q <= config_mode_i;
        end
    end

    assign rd_num_ch_o = num_ch;

    // the reader starts on the same cycle BUSY is seen low, so RD falls one cycle later
    assign rd_start_o = (state == CONV_WAIT_BUSY_LO) && !adc_busy_i;

    // ********************
    // conversion FSM
    // ********************

    always_ff @(posedge sys_clk) begin
        if (rst_i) begin
            state         <= CONV_IDLE;
            adc_cnvst_n_o <= 1'b1;
            cnvst_cnt     <= '0;
        end else begin
            case (state)
                CONV_IDLE: begin
                    // convert goes low on the cycle right after acceptance
                    if (accept) begin
                        adc_cnvst_n_o <= 1'b0;
                        cnvst_cnt     <= '0;
                        state         <= CONV_CONVERT;
                    end
                end
                CONV_CONVERT: begin
                    // count the low cycles of the convert pulse
                    if (cnvst_cnt == ADC_STROBE_CNT_W'(ADC_CNVST_CYCLES - 1)) begin
                        adc_cnvst_n_o <= 1'b1;
                        state         <= CONV_WAIT_BUSY_HI;
                    end else begin
                        cnvst_cnt <= cnvst_cnt + 1'b1;
                    end
                end
                CONV_WAIT_BUSY_HI: begin
                    // the ADC may take a few cycles to report that it is converting
                    if (adc_busy_i) begin
                        state <= CONV_WAIT_BUSY_LO;
                    end
                end
                CONV_WAIT_BUSY_LO: begin
                    // falling BUSY means the results are ready on the parallel bus
                    if (!adc_busy_i) begin
                        state <= CONV_READ;
                    end
                end
                CONV_READ: begin
                    if (rd_done_i) begin
                        state <= CONV_IDLE;
                    end
                end
                default: begin
                    state <= CONV_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: src/adc_rd_engine.sv
// one word in flight at a time and the ADC is assumed to advance its channel on every RD falling edge
`timescale 1ns/100ps
`default_nettype none

module adc_rd_engine import adc_capture_pkg::*; (
    input  wire             sys_clk,
    input  wire             rst_i,
    // frame control from the conversion controller
    input  wire             rd_start_i,
    input  wire adc_ch_t    rd_num_ch_i,
    output logic            rd_done_o,
    // ADC read pins
    output logic            adc_cs_n_o,
    output logic            adc_rd_n_o,
    input  wire adc_data_t  adc_db_i,
    // tagged words towards the sample FIFO
    output logic            word_valid_o,
    input  wire             word_ready_i,
    output adc_data_t       word_data_o,
    output adc_ch_t         word_ch_o,
    output logic            word_first_o
);

    rd_state_e                   state;
    logic [ADC_STROBE_CNT_W-1:0] cyc_cnt;
    adc_ch_t                     ch_cnt;
    adc_ch_t                     num_ch_q;
    logic                        start;
    logic                        capture;
    logic                        accept;
    logic                        last_word;
    logic                        gap_met;

    // a start pulse is only meaningful between frames
    assign start = rd_start_i && (state == RD_IDLE);

    // the bus is sampled on the last low cycle of RD
    assign capture = (state == RD_STROBE_LOW)
                     && (cyc_cnt == ADC_STROBE_CNT_W'(ADC_RD_LOW_CYCLES - 1));

    assign accept    = word_valid_o && word_ready_i;
    assign last_word = (ch_cnt == num_ch_q - adc_ch_t'(1));

    // cyc_cnt counts RD high cycles before the current one, so this covers the minimum gap
    assign gap_met = (cyc_cnt >= ADC_STROBE_CNT_W'(ADC_RD_HIGH_CYCLES - 1));

    // ********************
    // word capture
    // ********************

    // payload registers only change on a capture, so they hold while the FIFO stalls
    always_ff @(posedge sys_clk) begin
        if (start) begin
            num_ch_q <= rd_num_ch_i;
        end
        if (capture) begin
            word_data_o  <= adc_db_i;
            word_ch_o    <= ch_cnt;
            word_first_o <= (ch_cnt == '0);
        end
    end

    // ********************
    // strobe FSM
    // ********************

    always_ff @(posedge sys_clk) begin
        if (rst_i) begin
            state        <= RD_IDLE;
            adc_cs_n_o   <= 1'b1;
            adc_rd_n_o   <= 1'b1;
            word_valid_o <= 1'b0;
            rd_done_o    <= 1'b0;
            cyc_cnt      <= '0;
            ch_cnt       <= '0;
        end else begin
            // rd_done_o is a single-cycle pulse
            rd_done_o <= 1'b0;
            case (state)
                RD_IDLE: begin
                    // CS and the first RD fall together
                    if (start) begin
                        adc_cs_n_o <= 1'b0;
                        adc_rd_n_o <= 1'b0;
                        cyc_cnt    <= '0;
                        ch_cnt     <= '0;
                        state      <= RD_STROBE_LOW;
                    end
                end
                RD_STROBE_LOW: begin
                    if (capture) begin
                        adc_rd_n_o   <= 1'b1;
                        word_valid_o <= 1'b1;
                        cyc_cnt      <= '0;
                        state        <= RD_HOLD;
                    end else begin
                        cyc_cnt <= cyc_cnt + 1'b1;
                    end
                end
                RD_HOLD: begin
                    // RD stays high for as long as the FIFO refuses the word
                    if (accept) begin
                        word_valid_o <= 1'b0;
                        if (last_word) begin
                            // RD rose when this word was captured, so CS can go now
                            adc_cs_n_o <= 1'b1;
                            rd_done_o  <= 1'b1;
                            state      <= RD_IDLE;
                        end else begin
                            ch_cnt <= ch_cnt + 1'b1;
                            if (gap_met) begin
                                adc_rd_n_o <= 1'b0;
                                cyc_cnt    <= '0;
                                state      <= RD_STROBE_LOW;
                            end else begin
                                cyc_cnt <= cyc_cnt + 1'b1;
                                state   <= RD_GAP;
                            end
                        end
                    end else if (!gap_met) begin
                        cyc_cnt <= cyc_cnt + 1'b1;
                    end
                end
                RD_GAP: begin
                    // word already gone, only the minimum high time is left
                    if (gap_met) begin
                        adc_rd_n_o <= 1'b0;
                        cyc_cnt    <= '0;
                        state      <= RD_STROBE_LOW;
                    end else begin
                        cyc_cnt <= cyc_cnt + 1'b1;
                    end
                end
                default: begin
                    state <= RD_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: src/adc_sample_fifo.sv
// first-word-fall-through with registered outputs and a power-of-two depth from the package
`timescale 1ns/100ps
`default_nettype none

module adc_sample_fifo import adc_capture_pkg::*; (
    input  wire             sys_clk,
    input  wire             rst_i,
    // write side from the read engine
    input  wire             in_valid_i,
    output logic            in_ready_o,
    input  wire adc_data_t  in_data_i,
    input  wire adc_ch_t    in_ch_i,
    input  wire             in_first_i,
    // read side towards the consumer
    output logic            out_valid_o,
    input  wire             out_ready_i,
    output adc_data_t       out_data_o,
    output adc_ch_t         out_ch_o,
    output logic            out_first_o
);

    adc_data_t                  mem_data  [SAMPLE_FIFO_DEPTH];
    adc_ch_t                    mem_ch    [SAMPLE_FIFO_DEPTH];
    logic                       mem_first [SAMPLE_FIFO_DEPTH];
    logic [SAMPLE_FIFO_PTR_W-1:0] wr_ptr;
    logic [SAMPLE_FIFO_PTR_W-1:0] rd_ptr;
    logic [SAMPLE_FIFO_PTR_W-1:0] rd_ptr_nxt;
    logic [SAMPLE_FIFO_PTR_W:0]   count;
    logic [SAMPLE_FIFO_PTR_W:0]   count_nxt;
    logic                       wr;
    logic                       rd;

    // when full a write is still taken if the head leaves on the same cycle
    assign in_ready_o = (count != (SAMPLE_FIFO_PTR_W + 1)'(SAMPLE_FIFO_DEPTH)) || out_ready_i;

    assign wr = in_valid_i && in_ready_o;
    assign rd = out_valid_o && out_ready_i;

    assign rd_ptr_nxt = rd ? rd_ptr + 1'b1 : rd_ptr;

    always_comb begin
        case ({wr, rd})
            2'b10:   count_nxt = count + 1'b1;
            2'b01:   count_nxt = count - 1'b1;
            default: count_nxt = count;
        endcase
    end

    // ********************
    // storage
    // ********************

    always_ff @(posedge sys_clk) begin
        if (wr) begin
            mem_data[wr_ptr]  <= in_data_i;
            mem_ch[wr_ptr]    <= in_ch_i;
            mem_first[wr_ptr] <= in_first_i;
        end
        // the output registers always mirror the next head entry
        // a write landing on that head bypasses the memory, which gives the 1 cycle latency
        if (wr && (wr_ptr == rd_ptr_nxt)) begin
            out_data_o  <= in_data_i;
            out_ch_o    <= in_ch_i;
            out_first_o <= in_first_i;
        end else begin
            out_data_o  <= mem_data[rd_ptr_nxt];
            out_ch_o    <= mem_ch[rd_ptr_nxt];
            out_first_o <= mem_first[rd_ptr_nxt];
        end
    end

    // ********************
    // pointers and occupancy
    // ********************

    always_ff @(posedge sys_clk) begin
        if (rst_i) begin
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            count       <= '0;
            out_valid_o <= 1'b0;
        end else begin
            if (wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            rd_ptr      <= rd_ptr_nxt;
            count       <= count_nxt;
            out_valid_o <= (count_nxt != '0);
        end
    end

endmodule

`default_nettype wire

// File: src/adc_capture_top.sv
// 16-bit parallel ADC capture with the write strobe and bus tristate unused, so DB is input only
`timescale 1ns/100ps
`default_nettype none

module adc_capture_top import adc_capture_pkg::*; (
    input  wire             sys_clk,
    input  wire             rst_i,
    // conversion requests
    input  wire             conv_valid_i,
    output logic            conv_ready_o,
    input  wire adc_mode_t  config_mode_i,
    // ADC pins
    output logic            adc_cnvst_n_o,
    input  wire             adc_busy_i,
    output logic            adc_cs_n_o,
    output logic            adc_rd_n_o,
    input  wire adc_data_t  adc_db_i,
    // sample stream
    output logic            sample_valid_o,
    input  wire             sample_ready_i,
    output adc_data_t       sample_data_o,
    output adc_ch_t         sample_ch_o,
    output logic            sample_first_o
);

    // ********************
    // stage links
    // ********************

    // controller to read engine
    logic      rd_start;
    adc_ch_t   rd_num_ch;
    logic      rd_done;

    // read engine to FIFO
    logic      word_valid;
    logic      word_ready;
    adc_data_t word_data;
    adc_ch_t   word_ch;
    logic      word_first;

    // request handling, convert pulse and the BUSY wait
    adc_conv_ctrl i_conv_ctrl (
        .sys_clk       (sys_clk),
        .rst_i         (rst_i),
        .conv_valid_i  (conv_valid_i),
        .conv_ready_o  (conv_ready_o),
        .config_mode_i (config_mode_i),
        .adc_busy_i    (adc_busy_i),
        .adc_cnvst_n_o (adc_cnvst_n_o),
        .rd_start_o    (rd_start),
        .rd_num_ch_o   (rd_num_ch),
        .rd_done_i     (rd_done)
    );

    // CS and RD sequencing, one tagged word per channel
    adc_rd_engine i_rd_engine (
        .sys_clk      (sys_clk),
        .rst_i        (rst_i),
        .rd_start_i   (rd_start),
        .rd_num_ch_i  (rd_num_ch),
        .rd_done_o    (rd_done),
        .adc_cs_n_o   (adc_cs_n_o),
        .adc_rd_n_o   (adc_rd_n_o),
        .adc_db_i     (adc_db_i),
        .word_valid_o (word_valid),
        .word_ready_i (word_ready),
        .word_data_o  (word_data),
        .word_ch_o    (word_ch),
        .word_first_o (word_first)
    );

    // absorbs consumer stalls so the strobes only pause once it is full
    adc_sample_fifo i_sample_fifo (
        .sys_clk     (sys_clk),
        .rst_i       (rst_i),
        .in_valid_i  (word_valid),
        .in_ready_o  (word_ready),
        .in_data_i   (word_data),
        .in_ch_i     (word_ch),
        .in_first_i  (word_first),
        .out_valid_o (sample_valid_o),
        .out_ready_i (sample_ready_i),
        .out_data_o  (sample_data_o),
        .out_ch_o    (sample_ch_o),
        .out_first_o (sample_first_o)
    );

endmodule

`default_nettype wire

// File: verification/adc_parallel_model.sv
// behavioral parallel ADC whose BUSY length comes from busy_cycles_i and whose word is {conversion, channel}
`timescale 1ns/100ps
`default_nettype none

module adc_parallel_model import adc_capture_pkg::*; (
    input  wire        sys_clk,
    input  wire        adc_cnvst_n_i,
    output logic       adc_busy_o,
    input  wire        adc_cs_n_i,
    input  wire        adc_rd_n_i,
    output adc_data_t  adc_db_o,
    input  wire [4:0]  busy_cycles_i
);

    // the conversion number is the high byte of every word in a frame
    logic [7:0] conv_num = 8'd0;
    logic [7:0] word_idx = 8'd0;
    logic [4:0] busy_cnt = 5'd0;
    logic       busy_q   = 1'b0;
    adc_data_t  db_q     = '0;

    // pin levels seen at the previous clock, used for edge detection
    // they start low so a pin has to be seen high once before it can fall
    // the DUT reset drives every strobe high long before the first conversion
    logic       cnvst_q  = 1'b0;
    logic       cs_q     = 1'b0;
    logic       rd_q     = 1'b0;

    assign adc_busy_o = busy_q;
    assign adc_db_o   = db_q;

    // ********************
    // conversion
    // ********************

    // a falling convert strobe starts a new conversion and raises BUSY for busy_cycles_i clocks
    always @(posedge sys_clk) begin
        cnvst_q <= adc_cnvst_n_i;
        if (cnvst_q && !adc_cnvst_n_i) begin
            conv_num <= conv_num + 8'd1;
            busy_q   <= 1'b1;
            busy_cnt <= busy_cycles_i;
        end else if (busy_cnt != 5'd0) begin
            busy_cnt <= busy_cnt - 5'd1;
            if (busy_cnt == 5'd1) begin
                busy_q <= 1'b0;
            end
        end
    end

    // ********************
    // parallel read
    // ********************

    always @(posedge sys_clk) begin : read_port
        logic [7:0] idx;
        cs_q <= adc_cs_n_i;
        rd_q <= adc_rd_n_i;
        // CS falling restarts the channel index, so a frame cut by reset starts over at 0
        idx = (cs_q && !adc_cs_n_i) ? 8'd0 : word_idx;
        // the word appears right after RD falls and stays until the next falling edge
        if (rd_q && !adc_rd_n_i) begin
            db_q     <= {conv_num, idx};
            word_idx <= idx + 8'd1;
        end else begin
            word_idx <= idx;
        end
    end

endmodule

`default_nettype wire

// File: verification/adc_capture_sva.sv
// pin and stream checks for adc_capture_top, with adc_busy_i taken as synchronous to sys_clk
`timescale 1ns/100ps
`default_nettype none

module adc_capture_sva import adc_capture_pkg::*; (
    input wire            sys_clk,
    input wire            rst_i,
    input wire            conv_valid_i,
    input wire            conv_ready_i,
    input wire            cnvst_n_i,
    input wire            busy_i,
    input wire            cs_n_i,
    input wire            rd_n_i,
    input wire            sample_valid_i,
    input wire            sample_ready_i,
    input wire adc_data_t sample_data_i,
    input wire adc_ch_t   sample_ch_i,
    input wire            sample_first_i
);

    // ********************
    // ADC pins
    // ********************

    // a read strobe outside chip select would clock a word out of a deselected device
    rd_inside_cs: assert property (@(posedge sys_clk) disable iff (rst_i)
        !rd_n_i |-> !cs_n_i)
        else $error("RD is low while CS is high");

    // results are only valid on the bus once BUSY has dropped
    rd_not_busy: assert property (@(posedge sys_clk) disable iff (rst_i)
        !rd_n_i |-> !busy_i)
        else $error("RD is low while BUSY is high");

    // the rising edge must come exactly ADC_CNVST_CYCLES after the falling one
    cnvst_width: assert property (@(posedge sys_clk) disable iff (rst_i)
        $fell(cnvst_n_i) |-> ##ADC_CNVST_CYCLES $rose(cnvst_n_i))
        else $error("convert strobe low time differs from ADC_CNVST_CYCLES");

    rd_low_width: assert property (@(posedge sys_clk) disable iff (rst_i)
        $fell(rd_n_i) |-> ##ADC_RD_LOW_CYCLES $rose(rd_n_i))
        else $error("RD low time differs from ADC_RD_LOW_CYCLES");

    // ********************
    // request port
    // ********************

    accept_drops_ready: assert property (@(posedge sys_clk) disable iff (rst_i)
        conv_valid_i && conv_ready_i |=> !conv_ready_i)
        else $error("conv_ready stayed high after a request was accepted");

    // no new request may be taken while a frame is still being read
    no_ready_in_frame: assert property (@(posedge sys_clk) disable iff (rst_i)
        !cs_n_i |-> !conv_ready_i)
        else $error("conv_ready is high during a read frame");

    // ********************
    // sample stream
    // ********************

    stall_holds_sample: assert property (@(posedge sys_clk) disable iff (rst_i)
        sample_valid_i && !sample_ready_i |=> sample_valid_i
            && $stable(sample_data_i) && $stable(sample_ch_i) && $stable(sample_first_i))
        else $error("sample output changed while stalled");

endmodule

`default_nettype wire

// File: verification/tb_adc_capture.sv
// regression for adc_capture_top that needs the model's index to survive stalls and no BUSY at reset
`timescale 1ns/100ps
`default_nettype none

module tb_adc_capture import adc_capture_pkg::*; ();

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 16;
    // four mode frames, two stalled, four back to back and two around the reset
    localparam int NUM_CONV        = 12;
    localparam int WATCHDOG_CYCLES = NUM_CONV * 4000 + 2000;
    // channels per frame for modes 0 to 3
    localparam int CH_COUNT [4] = '{8, 9, 16, 17};

    logic       sys_clk;
    logic       rst;
    logic       conv_valid;
    logic       conv_ready;
    adc_mode_t  config_mode;
    logic       adc_cnvst_n;
    logic       adc_busy;
    logic       adc_cs_n;
    logic       adc_rd_n;
    adc_data_t  adc_db;
    logic       sample_valid;
    logic       sample_ready;
    adc_data_t  sample_data;
    adc_ch_t    sample_ch;
    logic       sample_first;
    logic [4:0] busy_cycles;

    int         seed = 32'h2fb1245d;
    logic       bp_en = 1'b0;
    adc_mode_t  mode_seq [4];

    // scoreboard state, owned by the monitor below
    logic [7:0]  conv_num = 8'd0;
    logic [21:0] exp_q [$];
    int          acc_cnt = 0;
    int          rx_cnt = 0;
    int          chk_cnt = 0;
    int          mon_err_cnt = 0;
    int          stim_err_cnt = 0;
    int          test_cnt = 0;

    adc_capture_top i_adc_capture_top (
        .sys_clk        (sys_clk),
        .rst_i          (rst),
        .conv_valid_i   (conv_valid),
        .conv_ready_o   (conv_ready),
        .config_mode_i  (config_mode),
        .adc_cnvst_n_o  (adc_cnvst_n),
        .adc_busy_i     (adc_busy),
        .adc_cs_n_o     (adc_cs_n),
        .adc_rd_n_o     (adc_rd_n),
        .adc_db_i       (adc_db),
        .sample_valid_o (sample_valid),
        .sample_ready_i (sample_ready),
        .sample_data_o  (sample_data),
        .sample_ch_o    (sample_ch),
        .sample_first_o (sample_first)
    );

    adc_parallel_model i_adc_model (
        .sys_clk       (sys_clk),
        .adc_cnvst_n_i (adc_cnvst_n),
        .adc_busy_o    (adc_busy),
        .adc_cs_n_i    (adc_cs_n),
        .adc_rd_n_i    (adc_rd_n),
        .adc_db_o      (adc_db),
        .busy_cycles_i (busy_cycles)
    );

    bind adc_capture_top adc_capture_sva i_adc_capture_sva (
        .sys_clk        (sys_clk),
        .rst_i          (rst_i),
        .conv_valid_i   (conv_valid_i),
        .conv_ready_i   (conv_ready_o),
        .cnvst_n_i      (adc_cnvst_n_o),
        .busy_i         (adc_busy_i),
        .cs_n_i         (adc_cs_n_o),
        .rd_n_i         (adc_rd_n_o),
        .sample_valid_i (sample_valid_o),
        .sample_ready_i (sample_ready_i),
        .sample_data_i  (sample_data_o),
        .sample_ch_i    (sample_ch_o),
        .sample_first_i (sample_first_o)
    );

    initial begin
        sys_clk = 1'b0;
        forever #(CLK_PERIOD / 2) sys_clk = ~sys_clk;
    end

    // ********************
    // random drive
    // ********************

    // BUSY length and consumer ready change every cycle, ready is always high without back-pressure
    initial begin : random_drive
        int r;
        sample_ready = 1'b0;
        busy_cycles  = 5'd5;
        forever begin
            @(posedge sys_clk);
            #2;
            r = $random(seed);
            busy_cycles = 5'(5 + ($unsigned(r) % 16));
            r = $random(seed);
            sample_ready = bp_en ? r[0] : 1'b1;
        end
    end

    // ********************
    // scoreboard
    // ********************

    // an accepted request queues its whole frame as {first, channel, conversion, channel}
    always @(posedge sys_clk) begin : scoreboard
        logic [21:0] got;
        logic [21:0] want;
        if (rst) begin
            exp_q.delete();
        end else begin
            if (conv_valid && conv_ready) begin
                conv_num = conv_num + 8'd1;
                acc_cnt++;
                for (int ch = 0; ch < CH_COUNT[config_mode]; ch++) begin
                    exp_q.push_back({ch == 0, 5'(ch), conv_num, 8'(ch)});
                end
            end
            if (sample_valid && sample_ready) begin
                got = {sample_first, sample_ch, sample_data};
                rx_cnt++;
                chk_cnt++;
                assert (exp_q.size() != 0) else begin
                    $display("sample %h arrived with no frame outstanding", got);
                    mon_err_cnt++;
                end
                if (exp_q.size() != 0) begin
                    want = exp_q.pop_front();
                    assert (got == want) else begin
                        $display("FAIL %0t: expected word %h, observed %h", $time, want, got);
                        mon_err_cnt++;
                    end
                end
            end
        end
    end

    function automatic int total_errors();
        return mon_err_cnt + stim_err_cnt;
    endfunction

    // ********************
    // stimulus tasks
    // ********************

    // holds valid until the scoreboard sees the handshake, keep_valid leaves it high for the next one
    task automatic request_conv(input adc_mode_t mode, input logic keep_valid);
        int acc0;
        acc0 = acc_cnt;
        config_mode = mode;
        conv_valid  = 1'b1;
        while (acc_cnt == acc0) begin
            @(posedge sys_clk);
            #2;
        end
        conv_valid = keep_valid;
    endtask

    // a frame is over when every queued sample has arrived and the controller is idle again
    task automatic wait_frames_done();
        while (exp_q.size() != 0 || !conv_ready) begin
            @(posedge sys_clk);
            #2;
        end
    endtask

    task automatic report_test(input string name, input int err0, input int rx0);
        test_cnt++;
        $display("test %s done: %0d samples, %0d errors", name, rx_cnt - rx0,
                 total_errors() - err0);
    endtask

    // ********************
    // test sequence
    // ********************

    initial begin : stimulus
        int err0;
        int rx0;
        int r;
        rst         = 1'b1;
        conv_valid  = 1'b0;
        config_mode = '0;
        for (int i = 0; i < 4; i++) begin
            r = $random(seed);
            mode_seq[i] = r[1:0];
        end
        repeat (RESET_CYCLES) @(posedge sys_clk);
        #2;
        rst = 1'b0;

        // one frame per mode with the consumer always ready
        err0 = total_errors();
        rx0  = rx_cnt;
        for (int m = 0; m < 4; m++) begin
            request_conv(adc_mode_t'(m), 1'b0);
            wait_frames_done();
        end
        report_test("modes", err0, rx0);

        // consumer stalls at random, the largest frames give the FIFO most to hold
        err0  = total_errors();
        rx0   = rx_cnt;
        bp_en = 1'b1;
        request_conv(2'd3, 1'b0);
        wait_frames_done();
        request_conv(2'd2, 1'b0);
        wait_frames_done();
        bp_en = 1'b0;
        report_test("backpressure", err0, rx0);

        // valid never drops, so each request is taken the cycle the previous frame ends
        err0 = total_errors();
        rx0  = rx_cnt;
        for (int i = 0; i < 4; i++) begin
            request_conv(mode_seq[i], i != 3);
        end
        wait_frames_done();
        report_test("back_to_back", err0, rx0);

        // reset lands once the first word of a 16-channel frame has come out
        err0 = total_errors();
        rx0  = rx_cnt;
        request_conv(2'd2, 1'b0);
        while (rx_cnt == rx0) begin
            @(posedge sys_clk);
            #2;
        end
        rst = 1'b1;
        repeat (3) begin
            @(posedge sys_clk);
            #2;
        end
        assert (adc_cnvst_n && adc_cs_n && adc_rd_n && !sample_valid) else begin
            $display("FAIL %0t: strobes or sample_valid not idle during reset", $time);
            stim_err_cnt++;
        end
        rst = 1'b0;
        @(posedge sys_clk);
        #2;
        assert (conv_ready) else begin
            $display("FAIL %0t: conv_ready low after reset release", $time);
            stim_err_cnt++;
        end
        request_conv(2'd1, 1'b0);
        wait_frames_done();
        report_test("mid_frame_reset", err0, rx0);

        $display("tests %0d, samples checked %0d, errors %0d", test_cnt, chk_cnt,
                 total_errors());
        if (total_errors() == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    // sized from the number of conversions, each one far shorter than 4000 cycles
    initial begin : watchdog
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog expired after %0d cycles before the tests finished", WATCHDOG_CYCLES);
        $display("Regression failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: sim.f
src/adc_capture_pkg.sv
src/adc_conv_ctrl.sv
src/adc_rd_engine.sv
src/adc_sample_fifo.sv
src/adc_capture_top.sv
verification/adc_parallel_model.sv
verification/adc_capture_sva.sv
verification/tb_adc_capture.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds the capture testbench with Verilator and runs it from the project root

set -u

cd "$(dirname "$0")" || exit 1

build_dir="obj_dir"
top="tb_adc_capture"

verilator --binary --timing --assert \
    --top-module "$top" \
    -Mdir "$build_dir" \
    -f sim.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

sim_out=$("./$build_dir/V$top" 2>&1)
sim_status=$?
printf '%s\n' "$sim_out"

if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx "Regression passed"; then
    exit 0
fi

echo "pass message not found in simulation output"
exit 1
